// File: hdl/sssp_pkg.sv
package sssp_pkg;

    // number of vertex lanes, and of updates carried in one word
    localparam int LANE_COUNT = 8;

    localparam int LANE_W = 64;
    localparam int WORD_W = LANE_COUNT * LANE_W;

    localparam int LEVEL_W = 8;
    localparam int VERTEX_W = 32;

    // set in a lane record that carries a candidate vertex
    localparam int LANE_PRESENT_BIT = 63;

    typedef logic [WORD_W-1:0] word_t;

    typedef logic [LANE_W-1:0] lane_t;

    typedef logic [LEVEL_W-1:0] level_t;

    typedef logic [VERTEX_W-1:0] vertex_t;

    typedef logic [LANE_COUNT-1:0] lane_mask_t;

    // holds 0 to 15, enough for a full buffer plus one incoming word
    typedef logic [3:0] slot_count_t;

endpackage

// File: hdl/sssp_lane.sv
`timescale 1ns/1ps

module sssp_lane #(
    parameter int ADDR_W  = 6,
    parameter int LANE_ID = 0
) (
    input  logic             clk,
    input  logic             rst,
    input  sssp_pkg::lane_t  record,
    input  logic             word_in_valid,
    input  sssp_pkg::level_t current_level,
    output sssp_pkg::lane_t  update,
    output logic             update_valid
);

    localparam int DEPTH = 2 ** ADDR_W;
    localparam int PAD_W = sssp_pkg::LANE_W - sssp_pkg::VERTEX_W - sssp_pkg::LEVEL_W;

    logic [DEPTH-1:0]  visited;
    logic [ADDR_W-1:0] local_idx;
    logic              hit;
    sssp_pkg::vertex_t global_id;

    assign local_idx = record[ADDR_W-1:0];

    // first visit of a present vertex in a valid word
    assign hit = word_in_valid && record[sssp_pkg::LANE_PRESENT_BIT] && !visited[local_idx];

    // vertices are interleaved across lanes by the low bits of the id
    assign global_id = sssp_pkg::vertex_t'(local_idx) * sssp_pkg::vertex_t'(sssp_pkg::LANE_COUNT)
                     + sssp_pkg::vertex_t'(LANE_ID);

    // test and set in the same cycle, so a vertex repeated in the next word is already marked
    always_ff @(posedge clk) begin
        if (rst) begin
            visited <= '0;
            update_valid <= 1'b0;
        end else begin
            update_valid <= hit;
            if (hit) begin
                visited[local_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            update <= {global_id, {PAD_W{1'b0}}, current_level};
        end
    end

    // a word that arrives during reset must not leak out as an update
    a_no_update_after_reset: assert property (@(posedge clk) rst |=> !update_valid)
        else $error("lane %0d emitted an update right after reset", LANE_ID);

endmodule

// File: hdl/update_compactor.sv
`timescale 1ns/1ps

module update_compactor (
    input  logic                  clk,
    input  logic                  rst,
    input  sssp_pkg::lane_t       lane_updates [sssp_pkg::LANE_COUNT],
    input  sssp_pkg::lane_mask_t  lane_valid,
    input  logic                  last_in,
    output sssp_pkg::word_t       packed_word,
    output sssp_pkg::slot_count_t count,
    output logic                  last_out
);

    localparam int LANES = sssp_pkg::LANE_COUNT;
    localparam int SLOT_W = sssp_pkg::LANE_W;
    localparam int TOP = sssp_pkg::WORD_W - 1;

    sssp_pkg::word_t       packed_next;
    sssp_pkg::slot_count_t fill;
    logic                  last_d1;

    // walk the lanes in order and drop each valid update into the next free slot
    always_comb begin
        packed_next = '0;
        fill = '0;
        for (int k = 0; k < LANES; k++) begin
            if (lane_valid[k]) begin
                packed_next[TOP - int'(fill) * SLOT_W -: SLOT_W] = lane_updates[k];
                fill = fill + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            last_d1 <= 1'b0;
            last_out <= 1'b0;
        end else begin
            count <= fill;
            // two stages here match the lane register plus this one
            last_d1 <= last_in;
            last_out <= last_d1;
        end
    end

    always_ff @(posedge clk) begin
        packed_word <= packed_next;
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= sssp_pkg::slot_count_t'(LANES))
        else $error("compacted count %0d exceeds the lane count", count);

endmodule

// File: hdl/update_packer.sv
`timescale 1ns/1ps

module update_packer (
    input  logic                  clk,
    input  logic                  rst,
    input  sssp_pkg::word_t       packed_word,
    input  sssp_pkg::slot_count_t count,
    input  logic                  last_in,
    output sssp_pkg::word_t       word_out,
    output logic                  valid_out,
    output logic                  done
);

    localparam int LANES = sssp_pkg::LANE_COUNT;
    localparam int SLOT_W = sssp_pkg::LANE_W;
    localparam int TOP = sssp_pkg::WORD_W - 1;
    localparam int HOLD = LANES - 1;
    localparam int MERGE = 2 * LANES - 1;

    typedef enum logic [1:0] {
        COLLECTING,
        FLUSHING,
        FINISHED
    } state_t;

    state_t                state;
    sssp_pkg::lane_t       held_buf [HOLD];
    sssp_pkg::slot_count_t held;
    sssp_pkg::slot_count_t in_count;
    sssp_pkg::slot_count_t total;
    sssp_pkg::lane_t       merged [MERGE];
    sssp_pkg::word_t       head_word;
    logic                  full;

    // incoming updates only count while still collecting
    assign in_count = (state == COLLECTING) ? count : '0;
    assign total = held + in_count;
    assign full = total >= sssp_pkg::slot_count_t'(LANES);

    // held updates first, then this cycle's updates right behind them
    always_comb begin
        for (int j = 0; j < MERGE; j++) begin
            merged[j] = '0;
        end
        for (int j = 0; j < HOLD; j++) begin
            if (j < int'(held)) begin
                merged[j] = held_buf[j];
            end
        end
        for (int k = 0; k < LANES; k++) begin
            if (k < int'(in_count)) begin
                merged[int'(held) + k] = packed_word[TOP - k * SLOT_W -: SLOT_W];
            end
        end
    end

    // the first eight merged entries form the candidate output word, zero padded
    always_comb begin
        head_word = '0;
        for (int k = 0; k < LANES; k++) begin
            head_word[TOP - k * SLOT_W -: SLOT_W] = merged[k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= COLLECTING;
            held <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            case (state)
                COLLECTING: begin
                    if (full) begin
                        valid_out <= 1'b1;
                        held <= total - sssp_pkg::slot_count_t'(LANES);
                    end else if (last_in) begin
                        // partial flush, only worth a word if it holds something
                        valid_out <= (total != '0);
                        held <= '0;
                    end else begin
                        held <= total;
                    end
                    if (last_in) begin
                        state <= FLUSHING;
                    end
                end
                FLUSHING: begin
                    // a leftover exists only when the last word overflowed a full one
                    valid_out <= (held != '0);
                    held <= '0;
                    if (held == '0) begin
                        state <= FINISHED;
                    end
                end
                default: begin
                    held <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        word_out <= head_word;
        for (int j = 0; j < HOLD; j++) begin
            held_buf[j] <= full ? merged[j + LANES] : merged[j];
        end
    end

    assign done = (state == FINISHED);

    a_quiet_when_finished: assert property (@(posedge clk) disable iff (rst)
        state == FINISHED |-> !valid_out)
        else $error("output word emitted after the run finished");

endmodule

// File: hdl/sssp_top.sv
`timescale 1ns/1ps

module sssp_top #(
    parameter int ADDR_W = 6
) (
    input  logic             clk,
    input  logic             rst,
    input  sssp_pkg::word_t  word_in,
    input  logic             word_in_valid,
    input  sssp_pkg::level_t current_level,
    input  logic             last_input_in,
    output sssp_pkg::word_t  word_out,
    output logic             valid_out,
    output logic             done
);

    localparam int LANE_W = sssp_pkg::LANE_W;
    localparam int TOP = sssp_pkg::WORD_W - 1;

    sssp_pkg::lane_t       lane_update [sssp_pkg::LANE_COUNT];
    sssp_pkg::lane_mask_t  lane_valid;
    sssp_pkg::word_t       packed_word;
    sssp_pkg::slot_count_t packed_count;
    logic                  packed_last;

    // lane 0 takes the top 64 bits of the input word
    for (genvar i = 0; i < sssp_pkg::LANE_COUNT; i++) begin : g_lane
        sssp_lane #(
            .ADDR_W  (ADDR_W),
            .LANE_ID (i)
        ) u_lane (
            .clk           (clk),
            .rst           (rst),
            .record        (word_in[TOP - i * LANE_W -: LANE_W]),
            .word_in_valid (word_in_valid),
            .current_level (current_level),
            .update        (lane_update[i]),
            .update_valid  (lane_valid[i])
        );
    end

    update_compactor u_compactor (
        .clk          (clk),
        .rst          (rst),
        .lane_updates (lane_update),
        .lane_valid   (lane_valid),
        .last_in      (last_input_in),
        .packed_word  (packed_word),
        .count        (packed_count),
        .last_out     (packed_last)
    );

    update_packer u_packer (
        .clk         (clk),
        .rst         (rst),
        .packed_word (packed_word),
        .count       (packed_count),
        .last_in     (packed_last),
        .word_out    (word_out),
        .valid_out   (valid_out),
        .done        (done)
    );

endmodule

// File: sim/tb_sssp_vectors.svh
// columns: present mask (lane 0 leftmost), local index bytes (lane 0 first),
// word valid, level, last input, random filler in the unused record bits

task automatic load_table();
    // idle cycles, then sparse words that build up a partial buffer
    add_row(8'b00000000, 64'h00_00_00_00_00_00_00_00, 1'b0, 8'd0, 1'b0, 1'b0);
    add_row(8'b00000000, 64'h00_00_00_00_00_00_00_00, 1'b0, 8'd0, 1'b0, 1'b1);
    add_row(8'b10100000, 64'h01_00_03_00_00_00_00_00, 1'b1, 8'd0, 1'b0, 1'b1);
    add_row(8'b00000100, 64'h00_00_00_00_00_00_00_00, 1'b1, 8'd0, 1'b0, 1'b0);
    // present records in a word that is not valid
    add_row(8'b11111111, 64'h10_11_12_13_14_15_16_17, 1'b0, 8'd1, 1'b0, 1'b1);
    // full word on top of three held updates
    add_row(8'b11111111, 64'h02_04_06_08_0a_0c_0e_10, 1'b1, 8'd1, 1'b0, 1'b1);
    // lane 0 index 1 again at a later level
    add_row(8'b10000001, 64'h01_00_00_00_00_00_00_09, 1'b1, 8'd2, 1'b0, 1'b0);
    add_row(8'b00010000, 64'h00_00_00_14_00_00_00_00, 1'b1, 8'd2, 1'b1, 1'b1);

    // after reset lane 0 index 1 is fresh again, and the last word overflows a full one
    add_row(8'b00000000, 64'h00_00_00_00_00_00_00_00, 1'b0, 8'd0, 1'b0, 1'b0);
    add_row(8'b11111111, 64'h01_02_02_02_02_02_02_02, 1'b1, 8'd0, 1'b0, 1'b0);
    add_row(8'b11111000, 64'h04_04_04_04_04_00_00_00, 1'b1, 8'd1, 1'b0, 1'b1);
    add_row(8'b11111111, 64'h05_05_05_05_05_05_05_05, 1'b1, 8'd2, 1'b1, 1'b1);

    // exactly one full word, then a last word of repeats, back to back on lanes 4 to 7
    add_row(8'b00000000, 64'h00_00_00_00_00_00_00_00, 1'b0, 8'd0, 1'b0, 1'b1);
    add_row(8'b11110000, 64'h07_07_07_07_00_00_00_00, 1'b1, 8'd3, 1'b0, 1'b1);
    add_row(8'b00001111, 64'h00_00_00_00_07_07_07_07, 1'b1, 8'd3, 1'b0, 1'b0);
    add_row(8'b11111111, 64'h07_07_07_07_07_07_07_07, 1'b1, 8'd4, 1'b1, 1'b1);
endtask

// File: sim/tb_sssp.sv
`timescale 1ns/1ps

module tb_sssp;

    localparam int ADDR_W = 6;
    localparam int PERIOD = 40;
    localparam int LANES = sssp_pkg::LANE_COUNT;
    localparam int LW = sssp_pkg::LANE_W;
    localparam int TOP = sssp_pkg::WORD_W - 1;

    // present bit 7 and the top index byte belong to lane 0
    typedef struct packed {
        sssp_pkg::lane_mask_t present;
        logic [63:0]          index_bytes;
        logic                 valid;
        sssp_pkg::level_t     level;
        logic                 last;
        logic                 fill;
    } row_t;

    logic             clk;
    logic             rst;
    sssp_pkg::word_t  word_in;
    logic             word_in_valid;
    sssp_pkg::level_t current_level;
    logic             last_input_in;
    sssp_pkg::word_t  word_out;
    logic             valid_out;
    logic             done;

    row_t            rows [$];
    sssp_pkg::word_t row_words [$];
    sssp_pkg::word_t expected [$];
    int              seg_end [$];
    int              got_count = 0;
    int              value_errors = 0;
    int              other_errors = 0;
    int              limit_cycles = 0;
    int              seed = 11;

    sssp_top #(
        .ADDR_W (ADDR_W)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .word_in       (word_in),
        .word_in_valid (word_in_valid),
        .current_level (current_level),
        .last_input_in (last_input_in),
        .word_out      (word_out),
        .valid_out     (valid_out),
        .done          (done)
    );

    task automatic add_row(input sssp_pkg::lane_mask_t present, input logic [63:0] index_bytes,
                           input logic valid, input sssp_pkg::level_t level,
                           input logic last, input logic fill);
        row_t row;
        row.present = present;
        row.index_bytes = index_bytes;
        row.valid = valid;
        row.level = level;
        row.last = last;
        row.fill = fill;
        rows.push_back(row);
    endtask

    `include "tb_sssp_vectors.svh"

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // bits between the index and the present bit carry random filler when asked
    task automatic build_word(input sssp_pkg::lane_mask_t present, input logic [63:0] index_bytes,
                              input logic fill, output sssp_pkg::word_t w);
        sssp_pkg::lane_t rec;
        logic [7:0]      idx_byte;
        w = '0;
        for (int k = 0; k < LANES; k++) begin
            rec = '0;
            if (fill) begin
                rec = {$random(seed), $random(seed)};
            end
            idx_byte = index_bytes[63 - 8 * k -: 8];
            rec[sssp_pkg::LANE_PRESENT_BIT] = present[LANES - 1 - k];
            rec[ADDR_W-1:0] = idx_byte[ADDR_W-1:0];
            w[TOP - LW * k -: LW] = rec;
        end
    endtask

    function automatic sssp_pkg::lane_t make_update(int lane, int idx, sssp_pkg::level_t level);
        sssp_pkg::vertex_t id;
        id = sssp_pkg::vertex_t'(idx * LANES + lane);
        return {id, {(LW - sssp_pkg::VERTEX_W - sssp_pkg::LEVEL_W){1'b0}}, level};
    endfunction

    // first visits in arrival order make eight updates per word and a partial word on last
    task automatic build_expected();
        logic [(2**ADDR_W)-1:0] seen [LANES];
        sssp_pkg::lane_t        pending [$];
        sssp_pkg::lane_t        rec;
        sssp_pkg::word_t        w;
        int                     idx;
        int                     s;
        for (int k = 0; k < LANES; k++) begin
            seen[k] = '0;
        end
        for (int r = 0; r < rows.size(); r++) begin
            if (rows[r].valid) begin
                for (int k = 0; k < LANES; k++) begin
                    rec = row_words[r][TOP - LW * k -: LW];
                    idx = int'(rec[ADDR_W-1:0]);
                    if (rec[sssp_pkg::LANE_PRESENT_BIT] && !seen[k][idx]) begin
                        seen[k][idx] = 1'b1;
                        pending.push_back(make_update(k, idx, rows[r].level));
                    end
                end
            end
            while (pending.size() >= LANES || (rows[r].last && pending.size() > 0)) begin
                w = '0;
                s = 0;
                while (s < LANES && pending.size() > 0) begin
                    w[TOP - LW * s -: LW] = pending.pop_front();
                    s++;
                end
                expected.push_back(w);
            end
            if (rows[r].last) begin
                seg_end.push_back(expected.size());
                for (int k = 0; k < LANES; k++) begin
                    seen[k] = '0;
                end
            end
        end
    endtask

    task automatic check_word(input string name, input sssp_pkg::word_t exp,
                              input sssp_pkg::word_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic drive_idle();
        word_in = '0;
        word_in_valid = 1'b0;
        current_level = '0;
        last_input_in = 1'b0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
    endtask

    // waits for done, then feeds one more word that must never reach the output
    task automatic finish_segment(input int seg);
        sssp_pkg::word_t w;
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        if (got_count != seg_end[seg]) begin
            $display("segment %0d reached done after %0d output words, %0d expected",
                     seg, got_count, seg_end[seg]);
            other_errors++;
        end
        build_word(8'hff, 64'h3f3f3f3f3f3f3f3f, 1'b0, w);
        word_in = w;
        word_in_valid = 1'b1;
        current_level = 8'hff;
        @(negedge clk);
        drive_idle();
        repeat (6) begin
            check_flag("done held", 1'b1, done);
            check_flag("quiet after done", 1'b0, valid_out);
            @(negedge clk);
        end
    endtask

    // outputs are sampled half a cycle after the edge that produced them
    always @(negedge clk) begin
        if (!rst && valid_out) begin
            if (got_count < expected.size()) begin
                check_word($sformatf("output word %0d", got_count), expected[got_count], word_out);
            end else begin
                $display("output word %0d arrived but only %0d were expected",
                         got_count, expected.size());
                other_errors++;
            end
            got_count++;
        end
    end

    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", limit_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        sssp_pkg::word_t w;
        int              seg;
        logic            seg_active;
        rst = 1'b1;
        drive_idle();
        load_table();
        for (int r = 0; r < rows.size(); r++) begin
            build_word(rows[r].present, rows[r].index_bytes, rows[r].fill, w);
            row_words.push_back(w);
        end
        build_expected();
        // each segment costs a reset, the pipeline drain and the checks after done
        limit_cycles = rows.size() + 20 + seg_end.size() * 32;
        apply_reset();
        seg = 0;
        seg_active = 1'b0;
        for (int r = 0; r < rows.size(); r++) begin
            @(negedge clk);
            if (!seg_active && !rows[r].valid) begin
                check_flag("idle valid_out", 1'b0, valid_out);
                check_flag("idle done", 1'b0, done);
            end
            if (rows[r].valid) begin
                seg_active = 1'b1;
            end
            word_in = row_words[r];
            word_in_valid = rows[r].valid;
            current_level = rows[r].level;
            last_input_in = rows[r].last;
            if (rows[r].last) begin
                @(negedge clk);
                drive_idle();
                finish_segment(seg);
                seg++;
                seg_active = 1'b0;
                if (r + 1 < rows.size()) begin
                    apply_reset();
                end
            end
        end
        if (got_count != expected.size()) begin
            $display("run ended with %0d output words, %0d expected", got_count, expected.size());
            other_errors++;
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+sim
hdl/sssp_pkg.sv
hdl/sssp_lane.sv
hdl/update_compactor.sv
hdl/update_packer.sv
hdl/sssp_top.sv
sim/tb_sssp.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sssp -f sources.f --Mdir "$BUILD_DIR" > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/Vtb_sssp" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -F -q "*** TEST FAILED ***" "$SIM_LOG"; then
    echo "simulation reported a failure, see $SIM_LOG"
    exit 1
fi

if ! grep -F -q "*** TEST PASSED ***" "$SIM_LOG"; then
    echo "simulation ended without a result line, see $SIM_LOG"
    exit 1
fi

exit 0
